// ==== core_defs_pkg.sv ====
package core_defs_pkg;

    // Bus and port widths
    typedef logic [31:0] data_t;       // Load and store data word
    typedef logic [31:0] data_addr_t;  // Byte address
    typedef logic [3:0]  byte_mask_t;  // One enable per byte lane

    // Width of a load or store
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'b00,
        ACCESS_HALF = 2'b01,
        ACCESS_WORD = 2'b10
    } data_access_t;

    // Data memory geometry
    localparam int MEM_WORDS  = 64;                  // Depth in words
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);   // Word index width
    localparam int MEM_WAIT   = 2;                   // Busy cycles per access
    localparam int WAIT_CNT_W = $clog2(MEM_WAIT + 1); // Wait counter width

endpackage

// ==== data_bus_if.sv ====
`timescale 1ns/100ps

interface data_bus_if;
    import core_defs_pkg::*;

    data_addr_t addr;   // Word-aligned address
    logic       re;     // Read enable
    logic       we;     // Write enable
    byte_mask_t be;     // Byte lanes to write
    data_t      wdata;  // Lane-placed write data
    data_t      rdata;  // Addressed word
    logic       busy;   // Wait state in progress

    modport master (
        output addr, re, we, be, wdata,
        input  rdata, busy
    );

    modport slave (
        input  addr, re, we, be, wdata,
        output rdata, busy
    );

endinterface

// ==== lsu_sequencer.sv ====
`timescale 1ns/100ps

module lsu_sequencer (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_req,         // Request strobe
    input  logic                        i_req_write,   // Store when high
    input  core_defs_pkg::data_access_t i_access,
    input  logic                        i_unsigned,
    input  core_defs_pkg::data_addr_t   i_addr,
    input  core_defs_pkg::data_t        i_wr_data,
    input  core_defs_pkg::data_t        i_rd_data,     // Extended load value
    input  logic                        i_mem_busy,
    input  logic                        i_align_error,
    output core_defs_pkg::data_addr_t   o_addr,
    output core_defs_pkg::data_access_t o_access,
    output logic                        o_unsigned,
    output core_defs_pkg::data_t        o_wr_data,
    output logic                        o_rd_enable,
    output logic                        o_wr_enable,
    output logic                        o_busy,
    output logic                        o_done,        // One-cycle completion
    output core_defs_pkg::data_t        o_result,
    output logic                        o_error
);
    import core_defs_pkg::*;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_ACCESS
    } seq_state_t;

    seq_state_t   state;
    data_addr_t   req_addr;
    data_access_t req_access;
    logic         req_unsigned;
    data_t        req_wr_data;
    logic         req_write;

    // Request register, loaded only when a strobe is accepted
    always_ff @(posedge i_clock) begin
        if (state == SEQ_IDLE && i_req) begin
            req_addr     <= i_addr;
            req_access   <= i_access;
            req_unsigned <= i_unsigned;
            req_wr_data  <= i_wr_data;
            req_write    <= i_req_write;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state    <= SEQ_IDLE;
            o_done   <= 1'b0;
            o_result <= '0;
            o_error  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                SEQ_IDLE:
                    if (i_req)
                        state <= SEQ_ACCESS;
                SEQ_ACCESS:
                    if (!i_mem_busy) begin  // Completion cycle on the bus
                        o_done   <= 1'b1;
                        o_result <= req_write ? '0 : i_rd_data;
                        o_error  <= i_align_error;
                        state    <= SEQ_IDLE;
                    end
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

    assign o_addr      = req_addr;
    assign o_access    = req_access;
    assign o_unsigned  = req_unsigned;
    assign o_wr_data   = req_wr_data;
    assign o_rd_enable = (state == SEQ_ACCESS) && !req_write;
    assign o_wr_enable = (state == SEQ_ACCESS) && req_write;
    assign o_busy      = (state == SEQ_ACCESS);

    // A completion always passes through idle before the next one
    assert property (@(posedge i_clock) disable iff (i_rst) o_done |=> !o_done);

    assert property (@(posedge i_clock) disable iff (i_rst) !(o_rd_enable && o_wr_enable));

endmodule

// ==== data_memory_adapter.sv ====
`timescale 1ns/100ps

module data_memory_adapter (
    input  core_defs_pkg::data_addr_t   i_addr,        // Byte address
    input  core_defs_pkg::data_access_t i_access,
    input  logic                        i_unsigned,    // Zero-extend loads
    input  logic                        i_wr_enable,
    input  logic                        i_rd_enable,
    input  core_defs_pkg::data_t        i_wr_data,
    output core_defs_pkg::data_t        o_rd_data,
    output logic                        o_busy,
    output logic                        o_align_error,
    data_bus_if.master                  bus
);
    import core_defs_pkg::*;

    byte_mask_t lane_mask;
    data_t      lane_wdata;

    assign bus.addr  = {i_addr[31:2], 2'b00};
    assign bus.re    = i_rd_enable & ~o_align_error;
    assign bus.we    = i_wr_enable & ~o_align_error;
    assign bus.be    = lane_mask;
    assign bus.wdata = lane_wdata;

    assign o_busy = bus.busy;

    // Half needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (i_access)
            ACCESS_BYTE: o_align_error = 1'b0;
            ACCESS_HALF: o_align_error = i_addr[0];
            ACCESS_WORD: o_align_error = |i_addr[1:0];
            default:     o_align_error = 1'b1;   // Reserved width code
        endcase
    end

    // Load side, lane select and extension
    always_comb begin
        o_rd_data = '0;
        case (i_access)
            ACCESS_BYTE:
                case (i_addr[1:0])
                    2'b00: o_rd_data = {{24{~i_unsigned & bus.rdata[7]}},  bus.rdata[7:0]};
                    2'b01: o_rd_data = {{24{~i_unsigned & bus.rdata[15]}}, bus.rdata[15:8]};
                    2'b10: o_rd_data = {{24{~i_unsigned & bus.rdata[23]}}, bus.rdata[23:16]};
                    default:
                        o_rd_data = {{24{~i_unsigned & bus.rdata[31]}}, bus.rdata[31:24]};
                endcase
            ACCESS_HALF:
                case (i_addr[1:0])
                    2'b00: o_rd_data = {{16{~i_unsigned & bus.rdata[15]}}, bus.rdata[15:0]};
                    2'b10: o_rd_data = {{16{~i_unsigned & bus.rdata[31]}}, bus.rdata[31:16]};
                    default: o_rd_data = '0;   // Misaligned, nothing returned
                endcase
            ACCESS_WORD:
                if (i_addr[1:0] == 2'b00)
                    o_rd_data = bus.rdata;
            default:
                o_rd_data = '0;
        endcase
    end

    // Store side, data placed in its lane with matching mask
    always_comb begin
        lane_wdata = '0;
        lane_mask  = 4'b0000;
        case (i_access)
            ACCESS_BYTE: begin
                lane_wdata = {4{i_wr_data[7:0]}};   // Replicated, mask picks the lane
                lane_mask  = 4'b0001 << i_addr[1:0];
            end
            ACCESS_HALF: begin
                lane_wdata = {2{i_wr_data[15:0]}};
                lane_mask  = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            ACCESS_WORD: begin
                lane_wdata = i_wr_data;
                lane_mask  = 4'b1111;
            end
            default: begin
                lane_wdata = '0;
                lane_mask  = 4'b0000;
            end
        endcase
        if (!i_wr_enable || o_align_error)
            lane_mask = 4'b0000;   // No lanes without an aligned write
    end

    // Byte enables stay quiet whenever no write reaches the bus
    always_comb begin
        assert final (bus.we || bus.be == '0);
    end

endmodule

// ==== data_memory.sv ====
`timescale 1ns/100ps

module data_memory (
    input  logic      i_clock,
    input  logic      i_rst,
    data_bus_if.slave bus
);
    import core_defs_pkg::*;

    data_t                 mem [MEM_WORDS];
    logic [WAIT_CNT_W-1:0] wait_cnt;     // Wait cycles spent on this access
    logic [MEM_ADDR_W-1:0] word_idx;
    logic                  access_en;
    logic                  complete;

    assign word_idx  = bus.addr[MEM_ADDR_W+1:2];
    assign access_en = bus.re | bus.we;
    assign bus.busy  = access_en && (wait_cnt != WAIT_CNT_W'(MEM_WAIT));
    assign complete  = access_en && !bus.busy;   // First enabled cycle not busy

    assign bus.rdata = mem[word_idx];

    always_ff @(posedge i_clock) begin
        if (i_rst)
            wait_cnt <= '0;
        else if (complete || !access_en)
            wait_cnt <= '0;                      // Ready for the next access
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    // Byte-lane write at the end of the completion cycle
    always_ff @(posedge i_clock) begin
        if (complete && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.be[i])
                    mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

    assert property (@(posedge i_clock) disable iff (i_rst) !(bus.re && bus.we));

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_req,          // One-cycle strobe
    input  logic                        i_req_write,
    input  core_defs_pkg::data_access_t i_access,
    input  logic                        i_unsigned,
    input  core_defs_pkg::data_addr_t   i_addr,
    input  core_defs_pkg::data_t        i_wr_data,
    output logic                        o_busy,
    output logic                        o_done,         // One-cycle pulse
    output core_defs_pkg::data_t        o_rd_data,
    output logic                        o_align_error
);
    import core_defs_pkg::*;

    data_addr_t   seq_addr;
    data_access_t seq_access;
    logic         seq_unsigned;
    data_t        seq_wr_data;
    logic         seq_rd_enable;
    logic         seq_wr_enable;
    data_t        adp_rd_data;
    logic         adp_busy;
    logic         adp_align_error;

    data_bus_if bus_i ();

    lsu_sequencer sequencer_i (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_req         (i_req),
        .i_req_write   (i_req_write),
        .i_access      (i_access),
        .i_unsigned    (i_unsigned),
        .i_addr        (i_addr),
        .i_wr_data     (i_wr_data),
        .i_rd_data     (adp_rd_data),
        .i_mem_busy    (adp_busy),
        .i_align_error (adp_align_error),
        .o_addr        (seq_addr),
        .o_access      (seq_access),
        .o_unsigned    (seq_unsigned),
        .o_wr_data     (seq_wr_data),
        .o_rd_enable   (seq_rd_enable),
        .o_wr_enable   (seq_wr_enable),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_result      (o_rd_data),
        .o_error       (o_align_error)
    );

    data_memory_adapter adapter_i (
        .i_addr        (seq_addr),
        .i_access      (seq_access),
        .i_unsigned    (seq_unsigned),
        .i_wr_enable   (seq_wr_enable),
        .i_rd_enable   (seq_rd_enable),
        .i_wr_data     (seq_wr_data),
        .o_rd_data     (adp_rd_data),
        .o_busy        (adp_busy),
        .o_align_error (adp_align_error),
        .bus           (bus_i.master)
    );

    data_memory memory_i (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .bus     (bus_i.slave)
    );

endmodule

// ==== tb_lsu_top.sv ====
`timescale 1ns/100ps

module tb_lsu_top;
    import core_defs_pkg::*;

    logic         i_clock;
    logic         i_rst;
    logic         i_req;
    logic         i_req_write;
    data_access_t i_access;
    logic         i_unsigned;
    data_addr_t   i_addr;
    data_t        i_wr_data;
    logic         o_busy;
    logic         o_done;
    data_t        o_rd_data;
    logic         o_align_error;

    string        case_name     [$];   // One entry per case line
    logic         case_write    [$];
    data_access_t case_access   [$];
    logic         case_unsigned [$];
    data_addr_t   case_addr     [$];
    data_t        case_wdata    [$];
    data_t        case_rdata    [$];
    logic         case_error    [$];

    int cycle_count = 0;
    int cycle_limit = 1000;

    lsu_top dut_i (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_req         (i_req),
        .i_req_write   (i_req_write),
        .i_access      (i_access),
        .i_unsigned    (i_unsigned),
        .i_addr        (i_addr),
        .i_wr_data     (i_wr_data),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_rd_data     (o_rd_data),
        .o_align_error (o_align_error)
    );

    always #50 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < cycle_limit) else
            stop_run($sformatf("Timeout, o_done never arrived within %0d cycles", cycle_limit));
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compare_value(input string test, input string signal,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else
            stop_run($sformatf("[FAIL] %s %s: expected %h, actual %h",
                               test, signal, expected, actual));
    endtask

    task automatic check_quiet_outputs(input string test);
        compare_value(test, "o_busy", 0, o_busy);
        compare_value(test, "o_done", 0, o_done);
        compare_value(test, "o_rd_data", 0, o_rd_data);
        compare_value(test, "o_align_error", 0, o_align_error);
    endtask

    task automatic read_cases();
        int          fd;
        int          fields;
        int          uns;
        int          err;
        string       line;
        string       name;
        string       op;
        string       width;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        fd = $fopen("lsu_cases.txt", "r");
        assert (fd != 0) else stop_run("Could not open the case file lsu_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %s %s %d %h %h %h %d",
                                 name, op, width, uns, addr, wdata, rdata, err);
                assert (fields == 8) else stop_run($sformatf("Malformed case line: %s", line));
                assert (op == "load" || op == "store") else
                    stop_run($sformatf("Unknown operation %s in case %s", op, name));
                case (width)
                    "byte":  case_access.push_back(ACCESS_BYTE);
                    "half":  case_access.push_back(ACCESS_HALF);
                    "word":  case_access.push_back(ACCESS_WORD);
                    default: stop_run($sformatf("Unknown width %s in case %s", width, name));
                endcase
                case_name.push_back(name);
                case_write.push_back(op == "store");
                case_unsigned.push_back(uns != 0);
                case_addr.push_back(addr);
                case_wdata.push_back(wdata);
                case_rdata.push_back(rdata);
                case_error.push_back(err != 0);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int idx);
        int cycles;
        int latency;
        latency = case_error[idx] ? 2 : MEM_WAIT + 2;  // Misaligned skips the bus
        @(posedge i_clock);
        i_req       <= 1'b1;
        i_req_write <= case_write[idx];
        i_access    <= case_access[idx];
        i_unsigned  <= case_unsigned[idx];
        i_addr      <= case_addr[idx];
        i_wr_data   <= case_wdata[idx];
        @(negedge i_clock);
        compare_value(case_name[idx], "o_busy before strobe", 0, o_busy);
        compare_value(case_name[idx], "o_done before strobe", 0, o_done);
        @(posedge i_clock);                              // Strobe sampled here
        i_req  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge i_clock);
            cycles++;
            if (!o_done) begin
                assert (o_busy) else
                    stop_run($sformatf("o_busy dropped before o_done in case %s",
                                       case_name[idx]));
                @(posedge i_clock);
                if (cycles == 1 && !case_error[idx]) begin  // Stray store while busy
                    i_req       <= 1'b1;
                    i_req_write <= 1'b1;
                    i_access    <= ACCESS_WORD;
                    i_addr      <= case_addr[idx];
                    i_wr_data   <= 32'hdead_beef;
                end else begin
                    i_req <= 1'b0;
                end
            end
        end while (!o_done);
        compare_value(case_name[idx], "latency", latency, cycles);
        compare_value(case_name[idx], "o_rd_data", case_rdata[idx], o_rd_data);
        compare_value(case_name[idx], "o_align_error", case_error[idx], o_align_error);
    endtask

    initial begin
        int idle;
        i_clock     = 1'b0;
        i_rst       = 1'b1;
        i_req       = 1'b0;
        i_req_write = 1'b0;
        i_access    = ACCESS_WORD;
        i_unsigned  = 1'b0;
        i_addr      = '0;
        i_wr_data   = '0;
        void'($urandom(32'h61ad_0d3b));
        read_cases();
        cycle_limit = case_name.size() * (MEM_WAIT + 2 + 3) + 50;
        repeat (7) begin
            @(negedge i_clock);
            check_quiet_outputs("reset");
        end
        @(posedge i_clock);
        i_rst <= 1'b0;                                   // Eighth reset edge
        @(negedge i_clock);
        check_quiet_outputs("after_reset");
        foreach (case_name[i]) begin
            idle = $urandom % 4;
            repeat (idle) @(posedge i_clock);
            run_case(i);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== lsu_cases.txt ====
# name op width unsigned addr wdata exp_rdata exp_error
# addr and data in hex, stores expect rdata 0
sw_w0    store word 0 00000000 8badf00d 00000000 0
sb_b1    store byte 0 00000001 ffffffa5 00000000 0
lw_merge load  word 0 00000000 00000000 8bada50d 0
lb_b0    load  byte 0 00000000 00000000 0000000d 0
lb_b1    load  byte 0 00000001 00000000 ffffffa5 0
lbu_b1   load  byte 1 00000001 00000000 000000a5 0
lb_b2    load  byte 0 00000002 00000000 ffffffad 0
lb_b3    load  byte 0 00000003 00000000 ffffff8b 0
lh_h0    load  half 0 00000000 00000000 ffffa50d 0
lhu_h0   load  half 1 00000000 00000000 0000a50d 0
lh_h2    load  half 0 00000002 00000000 ffff8bad 0
lhu_h2   load  half 1 00000002 00000000 00008bad 0
sw_w4    store word 0 00000004 01234567 00000000 0
sh_h6    store half 0 00000006 abcd7ffe 00000000 0
lh_h6    load  half 0 00000006 00000000 00007ffe 0
lb_b5    load  byte 0 00000005 00000000 00000045 0
sh_a5    store half 0 00000005 0000ffff 00000000 1
sw_a6    store word 0 00000006 ffffffff 00000000 1
lw_a1    load  word 0 00000001 00000000 00000000 1
lh_a3    load  half 0 00000003 00000000 00000000 1
lw_a7    load  word 0 00000007 00000000 00000000 1
lw_w4    load  word 0 00000004 00000000 7ffe4567 0

// ==== flist.f ====
core_defs_pkg.sv
data_bus_if.sv
lsu_sequencer.sv
data_memory_adapter.sv
data_memory.sv
lsu_top.sv
tb_lsu_top.sv
